//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fp_add_tb
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
design/fp_format_pkg.sv
design/fp_pipe_pkg.sv
design/lead_zero_count.sv
design/fp_unpack_compare.sv
design/fp_align_add.sv
design/fp_normalize_pack.sv
design/fp_add_top.sv
bench/fp_add_tb.sv

//--- bench/fp_add_tb.sv
`timescale 1ns/1ps

module fp_add_tb;
	import fp_format_pkg::*;
	import fp_pipe_pkg::*;

	localparam string TRACE_FILE = "bench/fp_add_trace.txt";
	localparam int    RESET_CYCLES = 5;

	logic     clk;
	logic     arst_n;
	logic     in_valid;
	fp_word_t in_a;
	fp_word_t in_b;
	logic     out_valid;
	fp_word_t out_sum;

	fp_word_t trace_a[$];
	fp_word_t trace_b[$];
	fp_word_t trace_sum[$];
	fp_word_t expected_q[$];  // One entry per pair in flight
	int       due_q[$];       // Cycle each result is due

	int value_errors;
	int latency_errors;
	int unexpected_outputs;
	int missing_outputs;
	int trace_errors;
	int cycle_count;
	int cycle_limit;

	fp_add_top uut (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_a      (in_a),
		.in_b      (in_b),
		.out_valid (out_valid),
		.out_sum   (out_sum)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic read_trace();
		int       fd;
		int       code;
		string    line;
		fp_word_t a;
		fp_word_t b;
		fp_word_t s;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the trace file %s", TRACE_FILE);
			trace_errors++;
			return;
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			// Comment and blank lines do not scan as three hex words
			if (code > 0 && $sscanf(line, "%h %h %h", a, b, s) == 3) begin
				trace_a.push_back(a);
				trace_b.push_back(b);
				trace_sum.push_back(s);
			end
		end
		$fclose(fd);
		if (trace_a.size() == 0) begin
			$display("The trace file holds no operand pairs");
			trace_errors++;
		end
	endtask

	// Called on a falling edge, returns one falling edge later
	task automatic drive_pair(input fp_word_t a, input fp_word_t b, input fp_word_t s);
		in_valid = 1'b1;
		in_a     = a;
		in_b     = b;
		expected_q.push_back(s);
		due_q.push_back(cycle_count + PIPE_LATENCY);
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic check_sum(input fp_word_t expected, input fp_word_t actual);
		if (actual !== expected) begin
			$display("ERROR out_sum: expected %08h, actual %08h", expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_latency(input int due, input int actual);
		if (actual != due) begin
			$display("A result came out at cycle %0d but was due at cycle %0d", actual, due);
			latency_errors++;
		end
	endtask

	always @(negedge clk) begin
		if (arst_n && out_valid) begin
			if (expected_q.size() == 0) begin
				$display("A result came out at cycle %0d with no pair waiting for it",
					cycle_count);
				unexpected_outputs++;
			end else begin
				check_sum(expected_q.pop_front(), out_sum);
				check_latency(due_q.pop_front(), cycle_count);
			end
		end
	end

	always @(posedge clk) begin
		if (arst_n) begin
			cycle_count++;
			if (cycle_limit > 0 && cycle_count > cycle_limit) begin
				$display("Timed out after %0d cycles with %0d results still missing",
					cycle_count, expected_q.size());
				$display("Simulation failed");
				$finish;
			end
		end
	end

	initial begin
		int gap;
		int drain_cycles;
		in_valid           = 1'b0;
		in_a               = '0;
		in_b               = '0;
		arst_n             = 1'b0;
		value_errors       = 0;
		latency_errors     = 0;
		unexpected_outputs = 0;
		missing_outputs    = 0;
		trace_errors       = 0;
		cycle_count        = 0;
		cycle_limit        = 0;
		void'($urandom(39));

		read_trace();
		// Trace runs twice, spaced and then as a burst
		cycle_limit = 2 * trace_a.size() * 3 + PIPE_LATENCY + 20;

		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;

		foreach (trace_a[i]) begin
			drive_pair(trace_a[i], trace_b[i], trace_sum[i]);
			gap = int'($urandom % 3);
			repeat (gap) @(negedge clk);
		end

		foreach (trace_a[i])
			drive_pair(trace_a[i], trace_b[i], trace_sum[i]);  // Three in flight

		drain_cycles = 0;
		while (expected_q.size() != 0 && drain_cycles < PIPE_LATENCY + 2) begin
			@(negedge clk);
			drain_cycles++;
		end
		repeat (PIPE_LATENCY + 2) @(negedge clk);  // Stray results

		missing_outputs = expected_q.size();
		if (missing_outputs != 0)
			$display("%0d expected results never came out", missing_outputs);
		$write("Errors: %0d wrong values, %0d mistimed results, %0d unexpected results, ",
			value_errors, latency_errors, unexpected_outputs);
		$display("%0d missing results, %0d trace problems", missing_outputs, trace_errors);
		if (value_errors + latency_errors + unexpected_outputs + missing_outputs
				+ trace_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- bench/fp_add_trace.txt
// a_hex b_hex expected_sum_hex, one operand pair per line
3F800000 3F800000 40000000
3F800000 40000000 40400000
3F800001 3F800000 40000000
41200000 3DCCCCCD 41219999
3F800001 BF800000 34000000
40000000 BFF00000 3E000000
40490FDB C0490FDB 00000000
4C000000 3F800000 4C000000
60000000 BF800000 60000000
7F800001 3F800000 7FC00000
7F800000 FF800000 7FC00000
FF800000 42280000 FF800000
00000000 C1200000 C1200000
80000000 80000000 80000000
00000001 3F800000 3F800000
7F7FFFFF 7F7FFFFF 7F800000
FF7FFFFF FF000000 FF800000
80800001 00800000 80000000
81000000 00C00000 80000000

//--- design/fp_add_top.sv
`timescale 1ns/1ps

module fp_add_top (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    in_valid,
	input  fp_format_pkg::fp_word_t in_a,
	input  fp_format_pkg::fp_word_t in_b,
	output logic                    out_valid,
	output fp_format_pkg::fp_word_t out_sum
);
	import fp_format_pkg::*;
	import fp_pipe_pkg::*;

	logic     s1_valid;
	logic     s1_special;
	fp_word_t s1_special_word;
	logic     s1_sign;
	fp_exp_t  s1_exp;
	sig_t     s1_sig_big;
	sig_t     s1_sig_small;
	lzc_t     s1_shift;
	logic     s1_sub;

	logic     s2_valid;
	logic     s2_special;
	fp_word_t s2_special_word;
	logic     s2_sign;
	fp_exp_t  s2_exp;
	sum_t     s2_sum;
	logic     s2_sub;

	fp_unpack_compare u_stage1 (
		.clk             (clk),
		.arst_n          (arst_n),
		.in_valid        (in_valid),
		.in_a            (in_a),
		.in_b            (in_b),
		.s1_valid        (s1_valid),
		.s1_special      (s1_special),
		.s1_special_word (s1_special_word),
		.s1_sign         (s1_sign),
		.s1_exp          (s1_exp),
		.s1_sig_big      (s1_sig_big),
		.s1_sig_small    (s1_sig_small),
		.s1_shift        (s1_shift),
		.s1_sub          (s1_sub)
	);

	fp_align_add u_stage2 (
		.clk             (clk),
		.arst_n          (arst_n),
		.s1_valid        (s1_valid),
		.s1_special      (s1_special),
		.s1_special_word (s1_special_word),
		.s1_sign         (s1_sign),
		.s1_exp          (s1_exp),
		.s1_sig_big      (s1_sig_big),
		.s1_sig_small    (s1_sig_small),
		.s1_shift        (s1_shift),
		.s1_sub          (s1_sub),
		.s2_valid        (s2_valid),
		.s2_special      (s2_special),
		.s2_special_word (s2_special_word),
		.s2_sign         (s2_sign),
		.s2_exp          (s2_exp),
		.s2_sum          (s2_sum),
		.s2_sub          (s2_sub)
	);

	fp_normalize_pack u_stage3 (
		.clk             (clk),
		.arst_n          (arst_n),
		.s2_valid        (s2_valid),
		.s2_special      (s2_special),
		.s2_special_word (s2_special_word),
		.s2_sign         (s2_sign),
		.s2_exp          (s2_exp),
		.s2_sum          (s2_sum),
		.s2_sub          (s2_sub),
		.out_valid       (out_valid),
		.out_sum         (out_sum)
	);

endmodule

//--- design/fp_align_add.sv
`timescale 1ns/1ps

module fp_align_add (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    s1_valid,
	input  logic                    s1_special,
	input  fp_format_pkg::fp_word_t s1_special_word,
	input  logic                    s1_sign,
	input  fp_format_pkg::fp_exp_t  s1_exp,
	input  fp_pipe_pkg::sig_t       s1_sig_big,
	input  fp_pipe_pkg::sig_t       s1_sig_small,
	input  fp_pipe_pkg::lzc_t       s1_shift,
	input  logic                    s1_sub,
	output logic                    s2_valid,
	output logic                    s2_special,
	output fp_format_pkg::fp_word_t s2_special_word,
	output logic                    s2_sign,
	output fp_format_pkg::fp_exp_t  s2_exp,
	output fp_pipe_pkg::sum_t       s2_sum,
	output logic                    s2_sub
);
	import fp_pipe_pkg::*;

	sig_t sig_aligned;
	sum_t big_ext;
	sum_t small_ext;
	sum_t sum;

	// Truncating alignment, a shift of SHIFT_MAX clears it
	assign sig_aligned = s1_sig_small >> s1_shift;

	assign big_ext   = {1'b0, s1_sig_big};
	assign small_ext = {1'b0, sig_aligned};

	always_comb begin
		if (s1_sub)
			sum = big_ext - small_ext;  // Never negative, big comes first
		else
			sum = big_ext + small_ext;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			s2_valid <= 1'b0;
		else
			s2_valid <= s1_valid;
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			s2_special      <= s1_special;
			s2_special_word <= s1_special_word;
			s2_sign         <= s1_sign;
			s2_exp          <= s1_exp;
			s2_sum          <= sum;
			s2_sub          <= s1_sub;
		end
	end

	// Relies on the magnitude ordering done in stage 1
	a_sub_no_borrow: assert property (@(posedge clk) disable iff (!arst_n)
		(s1_valid && s1_sub && !s1_special) |-> (s1_sig_big >= sig_aligned));

endmodule

//--- design/fp_format_pkg.sv
package fp_format_pkg;

	// binary32 field layout
	localparam int EXP_W  = 8;
	localparam int MAN_W  = 23;
	localparam int WORD_W = 32;

	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX  = 255;  // All-ones exponent, inf or NaN

	localparam logic [WORD_W-1:0] QNAN_WORD = 32'h7FC0_0000;

	typedef logic [WORD_W-1:0] fp_word_t;
	typedef logic [EXP_W-1:0]  fp_exp_t;
	typedef logic [MAN_W-1:0]  fp_man_t;

	typedef enum logic [1:0] {
		ZERO,
		NORMAL,
		INF,
		NAN
	} fp_class_t;

	// Denormals fall into ZERO
	function automatic fp_class_t fp_classify(input fp_exp_t exp, input fp_man_t man);
		fp_class_t cls;
		if (exp == '0) begin
			cls = ZERO;
		end else if (exp == fp_exp_t'(EXP_MAX)) begin
			if (man == '0)
				cls = INF;
			else
				cls = NAN;
		end else begin
			cls = NORMAL;
		end
		return cls;
	endfunction

endpackage

//--- design/fp_normalize_pack.sv
`timescale 1ns/1ps

module fp_normalize_pack (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    s2_valid,
	input  logic                    s2_special,
	input  fp_format_pkg::fp_word_t s2_special_word,
	input  logic                    s2_sign,
	input  fp_format_pkg::fp_exp_t  s2_exp,
	input  fp_pipe_pkg::sum_t       s2_sum,
	input  logic                    s2_sub,
	output logic                    out_valid,
	output fp_format_pkg::fp_word_t out_sum
);
	import fp_format_pkg::*;
	import fp_pipe_pkg::*;

	lzc_t                   lz;
	sig_t                   sig_norm;
	logic signed [EXP_W+1:0] exp_norm;  // Room for overflow and a negative result
	logic                   cancel;
	fp_word_t               word;

	lead_zero_count u_lzc (
		.sig   (s2_sum[SIG_W-1:0]),
		.count (lz)
	);

	always_comb begin
		if (s2_sum[SUM_W-1]) begin
			// Carry out, low bit dropped
			sig_norm = s2_sum[SUM_W-1:1];
			exp_norm = $signed({2'b00, s2_exp}) + 10'sd1;
		end else begin
			sig_norm = s2_sum[SIG_W-1:0] << lz;
			exp_norm = $signed({2'b00, s2_exp}) - $signed({5'b00000, lz});
		end
	end

	assign cancel = s2_sub && (s2_sum == '0);

	always_comb begin
		if (s2_special) begin
			word = s2_special_word;
		end else if (cancel) begin
			word = '0;  // Exact cancellation is +0
		end else if (exp_norm >= EXP_MAX) begin
			word = {s2_sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
		end else if (exp_norm <= 0) begin
			word = {s2_sign, {(WORD_W-1){1'b0}}};
		end else begin
			word = {s2_sign, exp_norm[EXP_W-1:0], sig_norm[MAN_W-1:0]};
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			out_valid <= 1'b0;
		else
			out_valid <= s2_valid;
	end

	always_ff @(posedge clk) begin
		if (s2_valid)
			out_sum <= word;
	end

	// Zero count and shift must agree
	a_hidden_bit: assert property (@(posedge clk) disable iff (!arst_n)
		(s2_valid && !s2_special && !cancel) |-> sig_norm[SIG_W-1]);

endmodule

//--- design/fp_pipe_pkg.sv
package fp_pipe_pkg;

	// Significand with the hidden bit in front
	localparam int SIG_W = 24;
	localparam int SUM_W = 25;  // One carry bit on top

	localparam int LZC_W = 5;

	// Alignment shift at which the small operand is gone
	localparam int SHIFT_MAX = 24;

	localparam int PIPE_LATENCY = 3;

	typedef logic [SIG_W-1:0] sig_t;
	typedef logic [SUM_W-1:0] sum_t;
	typedef logic [LZC_W-1:0] lzc_t;

endpackage

//--- design/fp_unpack_compare.sv
`timescale 1ns/1ps

module fp_unpack_compare (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    in_valid,
	input  fp_format_pkg::fp_word_t in_a,
	input  fp_format_pkg::fp_word_t in_b,
	output logic                    s1_valid,
	output logic                    s1_special,
	output fp_format_pkg::fp_word_t s1_special_word,
	output logic                    s1_sign,
	output fp_format_pkg::fp_exp_t  s1_exp,
	output fp_pipe_pkg::sig_t       s1_sig_big,
	output fp_pipe_pkg::sig_t       s1_sig_small,
	output fp_pipe_pkg::lzc_t       s1_shift,
	output logic                    s1_sub
);
	import fp_format_pkg::*;
	import fp_pipe_pkg::*;

	logic      sign_a;
	logic      sign_b;
	fp_exp_t   exp_a;
	fp_exp_t   exp_b;
	fp_man_t   man_a;
	fp_man_t   man_b;
	fp_class_t cls_a;
	fp_class_t cls_b;
	logic      a_is_big;
	fp_word_t  big_word;
	fp_word_t  small_word;
	fp_exp_t   exp_diff;
	lzc_t      shift;
	logic      special;
	fp_word_t  special_word;

	assign sign_a = in_a[WORD_W-1];
	assign sign_b = in_b[WORD_W-1];
	assign exp_a  = in_a[WORD_W-2 -: EXP_W];
	assign exp_b  = in_b[WORD_W-2 -: EXP_W];
	assign man_a  = in_a[MAN_W-1:0];
	assign man_b  = in_b[MAN_W-1:0];

	assign cls_a = fp_classify(exp_a, man_a);
	assign cls_b = fp_classify(exp_b, man_b);

	// Exponent then mantissa, both in one unsigned compare
	assign a_is_big   = in_a[WORD_W-2:0] >= in_b[WORD_W-2:0];
	assign big_word   = a_is_big ? in_a : in_b;
	assign small_word = a_is_big ? in_b : in_a;

	assign exp_diff = big_word[WORD_W-2 -: EXP_W] - small_word[WORD_W-2 -: EXP_W];
	assign shift    = (exp_diff >= SHIFT_MAX) ? lzc_t'(SHIFT_MAX) : exp_diff[LZC_W-1:0];

	always_comb begin
		special      = 1'b1;
		special_word = QNAN_WORD;
		if (cls_a == NAN || cls_b == NAN) begin
			special_word = QNAN_WORD;
		end else if (cls_a == INF && cls_b == INF) begin
			special_word = (sign_a == sign_b) ? in_a : QNAN_WORD;  // inf - inf
		end else if (cls_a == INF) begin
			special_word = in_a;
		end else if (cls_b == INF) begin
			special_word = in_b;
		end else if (cls_a == ZERO && cls_b == ZERO) begin
			special_word = {sign_a & sign_b, {(WORD_W-1){1'b0}}};
		end else if (cls_a == ZERO) begin
			special_word = in_b;
		end else if (cls_b == ZERO) begin
			special_word = in_a;
		end else begin
			special = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_special      <= special;
			s1_special_word <= special_word;
			s1_sign         <= big_word[WORD_W-1];
			s1_exp          <= big_word[WORD_W-2 -: EXP_W];
			s1_sig_big      <= {1'b1, big_word[MAN_W-1:0]};
			s1_sig_small    <= {1'b1, small_word[MAN_W-1:0]};
			s1_shift        <= shift;
			s1_sub          <= sign_a ^ sign_b;
		end
	end

	a_s1_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(s1_valid));

endmodule

//--- design/lead_zero_count.sv
`timescale 1ns/1ps

module lead_zero_count (
	input  fp_pipe_pkg::sig_t sig,
	output fp_pipe_pkg::lzc_t count
);
	import fp_pipe_pkg::*;

	localparam int GROUPS = SIG_W / 4;

	logic [GROUPS-1:0]      grp_zero;
	logic [GROUPS-1:0][1:0] grp_cnt;

	// Group 0 is the top nibble
	for (genvar g = 0; g < GROUPS; g++) begin : gen_grp
		logic [3:0] nib;
		logic [1:0] cnt;

		assign nib = sig[SIG_W-1-4*g -: 4];

		assign cnt[1] = ~(nib[3] | nib[2]);
		assign cnt[0] = (~nib[3] & nib[2]) | (~nib[3] & ~nib[1]);

		assign grp_zero[g] = ~|nib;
		assign grp_cnt[g]  = cnt;
	end

	// First group with a one wins
	always_comb begin
		count = lzc_t'(SIG_W);
		for (int g = GROUPS - 1; g >= 0; g--) begin
			if (!grp_zero[g])
				count = lzc_t'(4 * g) + lzc_t'(grp_cnt[g]);
		end
	end

endmodule
